// File: Bender.yml
package:
  name: soc_bus

sources:
  - design/soc_pkg.sv
  - design/mem_req_if.sv
  - design/mem_arbiter.sv
  - design/bus_decoder.sv
  - design/ram_block.sv
  - design/axi_timeout_timer.sv
  - design/axi_lite_master.sv
  - design/soc_bus_top.sv
  - target: test
    files:
      - tb/axi_lite_slave_model.sv
      - tb/tb_soc_bus.sv

// File: design/axi_lite_master.sv
`timescale 1ns/1ps

module axi_lite_master (
	input  logic                       clk_i,
	input  logic                       rst_i,
	mem_req_if.slave                   req_i,
	// write address
	output logic [soc_pkg::ADDR_W-1:0] m_axi_awaddr_o,
	output logic                       m_axi_awvalid_o,
	input  logic                       m_axi_awready_i,
	// write data
	output logic [soc_pkg::DATA_W-1:0] m_axi_wdata_o,
	output logic [soc_pkg::BE_W-1:0]   m_axi_wstrb_o,
	output logic                       m_axi_wvalid_o,
	input  logic                       m_axi_wready_i,
	// write response
	input  soc_pkg::axi_resp_t         m_axi_bresp_i,
	input  logic                       m_axi_bvalid_i,
	output logic                       m_axi_bready_o,
	// read address
	output logic [soc_pkg::ADDR_W-1:0] m_axi_araddr_o,
	output logic                       m_axi_arvalid_o,
	input  logic                       m_axi_arready_i,
	// read data
	input  logic [soc_pkg::DATA_W-1:0] m_axi_rdata_i,
	input  soc_pkg::axi_resp_t         m_axi_rresp_i,
	input  logic                       m_axi_rvalid_i,
	output logic                       m_axi_rready_o
);

typedef enum logic [2:0] {
	IDLE,
	WR_ADDR_DATA,
	WR_RESP,
	RD_ADDR,
	RD_DATA,
	DONE
} state_t;

state_t state_q;
logic [soc_pkg::ADDR_W-1:0] addr_q;  // shared by aw and ar
logic [soc_pkg::DATA_W-1:0] wdata_q;
logic [soc_pkg::BE_W-1:0]   strb_q;
logic [soc_pkg::DATA_W-1:0] rdata_q; // result handed back in DONE
logic aw_done_q, w_done_q;           // which write channels are through
logic aw_hs, w_hs;
logic b_err, r_err;
logic expired;

axi_timeout_timer u_timer (
	.clk_i     (clk_i),
	.rst_i     (rst_i),
	.run_i     (state_q != IDLE), // counts every busy cycle
	.expired_o (expired)
);

assign aw_hs = m_axi_awvalid_o & m_axi_awready_i;
assign w_hs  = m_axi_wvalid_o & m_axi_wready_i;
assign b_err = (m_axi_bresp_i == soc_pkg::SLVERR) || (m_axi_bresp_i == soc_pkg::DECERR);
assign r_err = (m_axi_rresp_i == soc_pkg::SLVERR) || (m_axi_rresp_i == soc_pkg::DECERR);

always_ff @(posedge clk_i) begin
	if (!rst_i) begin
		state_q   <= IDLE;
		aw_done_q <= 1'b0;
		w_done_q  <= 1'b0;
	end else begin
		case (state_q)
			IDLE: begin
				aw_done_q <= 1'b0;
				w_done_q  <= 1'b0;
				if (req_i.wr)
					state_q <= WR_ADDR_DATA; // aw and w together
				else if (req_i.rd)
					state_q <= RD_ADDR;
			end
			WR_ADDR_DATA: begin
				if (aw_hs) aw_done_q <= 1'b1;
				if (w_hs) w_done_q <= 1'b1;
				if (expired)
					state_q <= DONE;
				else if ((aw_done_q | aw_hs) && (w_done_q | w_hs))
					state_q <= WR_RESP;
			end
			WR_RESP: begin
				if (expired || m_axi_bvalid_i) state_q <= DONE;
			end
			RD_ADDR: begin
				if (expired)
					state_q <= DONE;
				else if (m_axi_arready_i)
					state_q <= RD_DATA;
			end
			RD_DATA: begin
				if (expired || m_axi_rvalid_i) state_q <= DONE;
			end
			default: state_q <= IDLE; // DONE lasts one cycle
		endcase
	end
end

// payload and result, no reset needed
always_ff @(posedge clk_i) begin
	if (state_q == IDLE) begin
		addr_q  <= req_i.addr;
		wdata_q <= req_i.wdata;
		strb_q  <= req_i.be; // wstrb straight from be
	end
	if (expired && state_q != IDLE && state_q != DONE)
		rdata_q <= soc_pkg::TIMEOUT_RDATA; // aborted
	else if (state_q == RD_DATA && m_axi_rvalid_i)
		rdata_q <= r_err ? soc_pkg::TIMEOUT_RDATA : m_axi_rdata_i;
	else if (state_q == WR_RESP && m_axi_bvalid_i)
		rdata_q <= b_err ? soc_pkg::TIMEOUT_RDATA : '0; // write status word
end

// channel controls straight from state, all drop on abort
assign m_axi_awvalid_o = (state_q == WR_ADDR_DATA) & ~aw_done_q;
assign m_axi_wvalid_o  = (state_q == WR_ADDR_DATA) & ~w_done_q;
assign m_axi_bready_o  = (state_q == WR_RESP);
assign m_axi_arvalid_o = (state_q == RD_ADDR);
assign m_axi_rready_o  = (state_q == RD_DATA);

assign m_axi_awaddr_o = addr_q;
assign m_axi_araddr_o = addr_q;
assign m_axi_wdata_o  = wdata_q;
assign m_axi_wstrb_o  = strb_q;

assign req_i.ready = (state_q == DONE);
assign req_i.rdata = rdata_q;

endmodule

// File: design/axi_timeout_timer.sv
`timescale 1ns/1ps

module axi_timeout_timer (
	input  logic clk_i,
	input  logic rst_i,
	input  logic run_i,    // bridge busy
	output logic expired_o
);

logic [$clog2(soc_pkg::AXI_TIMEOUT_CYCLES+1)-1:0] count_q;

// saturating count of busy cycles
always_ff @(posedge clk_i) begin
	if (!rst_i)
		count_q <= '0;
	else if (!run_i)
		count_q <= '0; // idle clears
	else if (!expired_o)
		count_q <= count_q + 1'b1;
end

assign expired_o = (count_q == $bits(count_q)'(soc_pkg::AXI_TIMEOUT_CYCLES));

endmodule

// File: design/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
	input  logic                      clk_i,
	input  logic                      rst_i,
	mem_req_if.slave                  bus_i, // from arbiter
	mem_req_if.master                 ram_o, // region 0
	mem_req_if.master                 axi_o, // everything else
	output logic [soc_pkg::LED_W-1:0] led_o
);

logic [soc_pkg::REGION_W-1:0] region;
logic sel_ram, sel_led, sel_axi;
logic led_access;
logic led_ready_q;

assign region  = bus_i.addr[soc_pkg::ADDR_W-1:soc_pkg::REGION_LSB];
assign sel_ram = (region == soc_pkg::REGION_RAM);
assign sel_led = (region == soc_pkg::REGION_LED);
assign sel_axi = ~sel_ram & ~sel_led;

// ram target, strobes gated by region
assign ram_o.rd    = bus_i.rd & sel_ram;
assign ram_o.wr    = bus_i.wr & sel_ram;
assign ram_o.addr  = bus_i.addr;
assign ram_o.wdata = bus_i.wdata;
assign ram_o.be    = bus_i.be;

// axi bridge target
assign axi_o.rd    = bus_i.rd & sel_axi;
assign axi_o.wr    = bus_i.wr & sel_axi;
assign axi_o.addr  = bus_i.addr;
assign axi_o.wdata = bus_i.wdata;
assign axi_o.be    = bus_i.be;

// led register, one cycle ready like the ram
assign led_access = sel_led & (bus_i.rd | bus_i.wr) & ~led_ready_q;

always_ff @(posedge clk_i) begin
	if (!rst_i) begin
		led_ready_q <= 1'b0;
		led_o       <= '0;
	end else begin
		led_ready_q <= led_access; // never twice in a row
		if (led_access && bus_i.wr)
			led_o <= bus_i.wdata[soc_pkg::LED_W-1:0]; // be ignored here
	end
end

// steer the response of the selected target
always_comb begin
	if (sel_ram) begin
		bus_i.ready = ram_o.ready;
		bus_i.rdata = ram_o.rdata;
	end else if (sel_led) begin
		bus_i.ready = led_ready_q;
		bus_i.rdata = {{(soc_pkg::DATA_W-soc_pkg::LED_W){1'b0}}, led_o}; // zero ext
	end else begin
		bus_i.ready = axi_o.ready;
		bus_i.rdata = axi_o.rdata;
	end
end

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                       clk_i,
	input  logic                       rst_i,
	// instruction fetch port, read only
	input  logic                       instr_rd_i,
	input  logic [soc_pkg::ADDR_W-1:0] instr_addr_i,
	output logic                       instr_ready_o,
	output logic [soc_pkg::DATA_W-1:0] instr_rdata_o,
	// data port
	input  logic                       data_rd_i,
	input  logic                       data_wr_i,
	input  logic [soc_pkg::ADDR_W-1:0] data_addr_i,
	input  logic [soc_pkg::DATA_W-1:0] data_wdata_i,
	input  logic [soc_pkg::BE_W-1:0]   data_be_i,
	output logic                       data_ready_o,
	output logic [soc_pkg::DATA_W-1:0] data_rdata_o,
	// merged bus
	mem_req_if.master                  bus_o
);

typedef enum logic [1:0] {
	IDLE,
	SERVE_DATA,
	SERVE_INSTR
} state_t;

state_t state_q, state_d;
logic instr_lost_q, instr_lost_d; // loser of the last tie, 1 = instr
logic instr_wait, data_wait;

assign instr_wait = instr_rd_i;
assign data_wait  = data_rd_i | data_wr_i;

always_comb begin
	state_d      = state_q;
	instr_lost_d = instr_lost_q;
	case (state_q)
		IDLE: begin
			if (instr_wait && data_wait) begin // tie, last loser goes first
				state_d      = instr_lost_q ? SERVE_INSTR : SERVE_DATA;
				instr_lost_d = ~instr_lost_q;
			end else if (data_wait) begin
				state_d = SERVE_DATA;
			end else if (instr_wait) begin
				state_d = SERVE_INSTR;
			end
		end
		SERVE_DATA,
		SERVE_INSTR: begin
			if (bus_o.ready) state_d = IDLE; // grant held until ready
		end
		default: state_d = IDLE;
	endcase
end

always_ff @(posedge clk_i) begin
	if (!rst_i) begin
		state_q      <= IDLE;
		instr_lost_q <= 1'b0; // data wins the first tie
	end else begin
		state_q      <= state_d;
		instr_lost_q <= instr_lost_d;
	end
end

// forward the granted request only
always_comb begin
	bus_o.rd    = 1'b0;
	bus_o.wr    = 1'b0;
	bus_o.addr  = '0;
	bus_o.wdata = '0;
	bus_o.be    = '0;
	if (state_q == SERVE_DATA) begin
		bus_o.rd    = data_rd_i;
		bus_o.wr    = data_wr_i;
		bus_o.addr  = data_addr_i;
		bus_o.wdata = data_wdata_i;
		bus_o.be    = data_be_i;
	end else if (state_q == SERVE_INSTR) begin
		bus_o.rd    = instr_rd_i;
		bus_o.addr  = instr_addr_i;
		bus_o.be    = '1; // fetches are full words
	end
end

// completion goes back to the owner of the grant
assign data_ready_o  = (state_q == SERVE_DATA) & bus_o.ready;
assign instr_ready_o = (state_q == SERVE_INSTR) & bus_o.ready;
assign data_rdata_o  = (state_q == SERVE_DATA) ? bus_o.rdata : '0;
assign instr_rdata_o = (state_q == SERVE_INSTR) ? bus_o.rdata : '0;

endmodule

// File: design/mem_req_if.sv
`timescale 1ns/1ps

// simple level request bus, request held until one-cycle ready
interface mem_req_if;

logic                         rd;    // read request
logic                         wr;    // write request
logic [soc_pkg::ADDR_W-1:0]   addr;  // byte address
logic [soc_pkg::DATA_W-1:0]   wdata;
logic [soc_pkg::BE_W-1:0]     be;    // byte enables, writes only
logic                         ready; // one cycle, ends the access
logic [soc_pkg::DATA_W-1:0]   rdata; // valid with ready

// requester side
modport master (
	output rd, wr, addr, wdata, be,
	input  ready, rdata
);

// target side
modport slave (
	input  rd, wr, addr, wdata, be,
	output ready, rdata
);

endinterface

// File: design/ram_block.sv
`timescale 1ns/1ps

module ram_block (
	input  logic     clk_i,
	input  logic     rst_i,
	mem_req_if.slave req_i
);

logic [soc_pkg::DATA_W-1:0]     mem [2**soc_pkg::RAM_ADDR_W]; // 128 KiB
logic [soc_pkg::RAM_ADDR_W-1:0] word_addr;
logic [soc_pkg::DATA_W-1:0]     rdata_q;
logic                           ready_q;
logic                           access;

assign word_addr = req_i.addr[soc_pkg::RAM_ADDR_W+1:2]; // addr[16:2]
assign access    = (req_i.rd | req_i.wr) & ~ready_q;    // skip the ready cycle

always_ff @(posedge clk_i) begin
	if (!rst_i)
		ready_q <= 1'b0;
	else
		ready_q <= access;
end

// byte lane writes, registered read
always_ff @(posedge clk_i) begin
	if (access && req_i.wr) begin
		for (int b = 0; b < soc_pkg::BE_W; b++) begin
			if (req_i.be[b])
				mem[word_addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
		end
	end
	if (access && req_i.rd)
		rdata_q <= mem[word_addr]; // be not looked at on reads
end

assign req_i.ready = ready_q;
assign req_i.rdata = rdata_q;

endmodule

// File: design/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
	input  logic                       clk_i,
	input  logic                       rst_i,
	// instruction fetch port
	input  logic                       instr_rd_i,
	input  logic [soc_pkg::ADDR_W-1:0] instr_addr_i,
	output logic                       instr_ready_o,
	output logic [soc_pkg::DATA_W-1:0] instr_rdata_o,
	// data port
	input  logic                       data_rd_i,
	input  logic                       data_wr_i,
	input  logic [soc_pkg::ADDR_W-1:0] data_addr_i,
	input  logic [soc_pkg::DATA_W-1:0] data_wdata_i,
	input  logic [soc_pkg::BE_W-1:0]   data_be_i,
	output logic                       data_ready_o,
	output logic [soc_pkg::DATA_W-1:0] data_rdata_o,
	output logic [soc_pkg::LED_W-1:0]  led_o,
	// axi4-lite master
	output logic [soc_pkg::ADDR_W-1:0] m_axi_awaddr_o,
	output logic                       m_axi_awvalid_o,
	input  logic                       m_axi_awready_i,
	output logic [soc_pkg::DATA_W-1:0] m_axi_wdata_o,
	output logic [soc_pkg::BE_W-1:0]   m_axi_wstrb_o,
	output logic                       m_axi_wvalid_o,
	input  logic                       m_axi_wready_i,
	input  soc_pkg::axi_resp_t         m_axi_bresp_i,
	input  logic                       m_axi_bvalid_i,
	output logic                       m_axi_bready_o,
	output logic [soc_pkg::ADDR_W-1:0] m_axi_araddr_o,
	output logic                       m_axi_arvalid_o,
	input  logic                       m_axi_arready_i,
	input  logic [soc_pkg::DATA_W-1:0] m_axi_rdata_i,
	input  soc_pkg::axi_resp_t         m_axi_rresp_i,
	input  logic                       m_axi_rvalid_i,
	output logic                       m_axi_rready_o
);

mem_req_if bus_if (); // arbiter to decoder
mem_req_if ram_if (); // decoder to ram
mem_req_if axi_if (); // decoder to bridge

mem_arbiter u_arbiter (
	.clk_i         (clk_i),
	.rst_i         (rst_i),
	.instr_rd_i    (instr_rd_i),
	.instr_addr_i  (instr_addr_i),
	.instr_ready_o (instr_ready_o),
	.instr_rdata_o (instr_rdata_o),
	.data_rd_i     (data_rd_i),
	.data_wr_i     (data_wr_i),
	.data_addr_i   (data_addr_i),
	.data_wdata_i  (data_wdata_i),
	.data_be_i     (data_be_i),
	.data_ready_o  (data_ready_o),
	.data_rdata_o  (data_rdata_o),
	.bus_o         (bus_if)
);

bus_decoder u_decoder (
	.clk_i (clk_i),
	.rst_i (rst_i),
	.bus_i (bus_if),
	.ram_o (ram_if),
	.axi_o (axi_if),
	.led_o (led_o)
);

ram_block u_ram (
	.clk_i (clk_i),
	.rst_i (rst_i),
	.req_i (ram_if)
);

axi_lite_master u_axi_master (
	.clk_i           (clk_i),
	.rst_i           (rst_i),
	.req_i           (axi_if),
	.m_axi_awaddr_o  (m_axi_awaddr_o),
	.m_axi_awvalid_o (m_axi_awvalid_o),
	.m_axi_awready_i (m_axi_awready_i),
	.m_axi_wdata_o   (m_axi_wdata_o),
	.m_axi_wstrb_o   (m_axi_wstrb_o),
	.m_axi_wvalid_o  (m_axi_wvalid_o),
	.m_axi_wready_i  (m_axi_wready_i),
	.m_axi_bresp_i   (m_axi_bresp_i),
	.m_axi_bvalid_i  (m_axi_bvalid_i),
	.m_axi_bready_o  (m_axi_bready_o),
	.m_axi_araddr_o  (m_axi_araddr_o),
	.m_axi_arvalid_o (m_axi_arvalid_o),
	.m_axi_arready_i (m_axi_arready_i),
	.m_axi_rdata_i   (m_axi_rdata_i),
	.m_axi_rresp_i   (m_axi_rresp_i),
	.m_axi_rvalid_i  (m_axi_rvalid_i),
	.m_axi_rready_o  (m_axi_rready_o)
);

endmodule

// File: design/soc_pkg.sv
package soc_pkg;

// bus geometry
localparam int ADDR_W = 32;
localparam int DATA_W = 32;
localparam int BE_W   = DATA_W / 8; // one enable per byte

// region field sits in addr[31:17], 128 KiB per region
localparam int REGION_LSB = 17;
localparam int REGION_W   = ADDR_W - REGION_LSB;

localparam logic [REGION_W-1:0] REGION_RAM = 15'd0; // word ram
localparam logic [REGION_W-1:0] REGION_LED = 15'd1; // led register
// anything else goes out on axi

localparam int RAM_ADDR_W = REGION_LSB - 2; // word index, addr[16:2]
localparam int LED_W      = 4;

// hung axi access guard
localparam int AXI_TIMEOUT_CYCLES = 64;
localparam logic [DATA_W-1:0] TIMEOUT_RDATA = 32'hDEAD_BEEF; // returned on abort

// axi response codes
typedef enum logic [1:0] {
	OKAY   = 2'b00,
	EXOKAY = 2'b01,
	SLVERR = 2'b10,
	DECERR = 2'b11
} axi_resp_t;

endpackage

// File: tb/axi_lite_slave_model.sv
`timescale 1ns/1ps

// axi4-lite memory model, random stalls on every ready
module axi_lite_slave_model (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  logic [soc_pkg::ADDR_W-1:0] s_axi_awaddr_i,
	input  logic                       s_axi_awvalid_i,
	output logic                       s_axi_awready_o,
	input  logic [soc_pkg::DATA_W-1:0] s_axi_wdata_i,
	input  logic [soc_pkg::BE_W-1:0]   s_axi_wstrb_i,
	input  logic                       s_axi_wvalid_i,
	output logic                       s_axi_wready_o,
	output soc_pkg::axi_resp_t         s_axi_bresp_o,
	output logic                       s_axi_bvalid_o,
	input  logic                       s_axi_bready_i,
	input  logic [soc_pkg::ADDR_W-1:0] s_axi_araddr_i,
	input  logic                       s_axi_arvalid_i,
	output logic                       s_axi_arready_o,
	output logic [soc_pkg::DATA_W-1:0] s_axi_rdata_o,
	output soc_pkg::axi_resp_t         s_axi_rresp_o,
	output logic                       s_axi_rvalid_o,
	input  logic                       s_axi_rready_i
);

logic [soc_pkg::DATA_W-1:0] mem [logic [soc_pkg::ADDR_W-1:0]]; // sparse store
integer seed = 32'h1134;

// 0 to 5 idle cycles
task automatic stall();
	int n;
	n = $unsigned($random(seed)) % 6;
	repeat (n) @(posedge clk_i);
endtask

// top nibble F never answers
function automatic logic silent(input logic [soc_pkg::ADDR_W-1:0] addr);
	return addr[soc_pkg::ADDR_W-1 -: 4] == 4'hF;
endfunction

task automatic serve_write();
	logic [soc_pkg::DATA_W-1:0] word;
	stall();
	s_axi_awready_o <= 1'b1; // aw and w taken in the same cycle
	s_axi_wready_o  <= 1'b1;
	@(posedge clk_i);
	s_axi_awready_o <= 1'b0;
	s_axi_wready_o  <= 1'b0;
	word = mem.exists(s_axi_awaddr_i) ? mem[s_axi_awaddr_i] : '0; // unwritten reads 0
	for (int b = 0; b < soc_pkg::BE_W; b++) begin
		if (s_axi_wstrb_i[b])
			word[8*b +: 8] = s_axi_wdata_i[8*b +: 8];
	end
	mem[s_axi_awaddr_i] = word;
	stall();
	s_axi_bresp_o  <= soc_pkg::OKAY;
	s_axi_bvalid_o <= 1'b1;
	do
		@(posedge clk_i);
	while (!s_axi_bready_i);
	s_axi_bvalid_o <= 1'b0;
endtask

task automatic serve_read();
	logic [soc_pkg::ADDR_W-1:0] addr;
	addr = s_axi_araddr_i;
	stall();
	s_axi_arready_o <= 1'b1;
	@(posedge clk_i);
	s_axi_arready_o <= 1'b0;
	stall();
	s_axi_rdata_o  <= mem.exists(addr) ? mem[addr] : '0;
	s_axi_rresp_o  <= soc_pkg::OKAY;
	s_axi_rvalid_o <= 1'b1;
	do
		@(posedge clk_i);
	while (!s_axi_rready_i);
	s_axi_rvalid_o <= 1'b0;
endtask

initial begin
	s_axi_awready_o = 1'b0;
	s_axi_wready_o  = 1'b0;
	s_axi_bresp_o   = soc_pkg::OKAY;
	s_axi_bvalid_o  = 1'b0;
	s_axi_arready_o = 1'b0;
	s_axi_rdata_o   = '0;
	s_axi_rresp_o   = soc_pkg::OKAY;
	s_axi_rvalid_o  = 1'b0;
	forever begin
		@(posedge clk_i);
		if (rst_i && s_axi_awvalid_i && s_axi_wvalid_i && !silent(s_axi_awaddr_i))
			serve_write();
		else if (rst_i && s_axi_arvalid_i && !silent(s_axi_araddr_i))
			serve_read();
	end
end

endmodule

// File: tb/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;

localparam int CLK_PERIOD   = 40;
localparam int RESET_CYCLES = 5;
localparam int NUM_ACCESSES = 18; // every request issued below
localparam logic [31:0] RAM_A      = 32'h0000_0100;
localparam logic [31:0] RAM_B      = 32'h0000_0200;
localparam logic [31:0] RAM_B_WORD = 32'h5566_7788;
localparam logic [31:0] LED_A      = 32'h0002_0100; // region 1, same low bits as RAM_A
localparam logic [31:0] AXI_A      = 32'h4000_0010;
localparam logic [31:0] SILENT_A   = 32'hF000_0000;

logic clk_i;
logic rst_i;
logic instr_rd_i;
logic [soc_pkg::ADDR_W-1:0] instr_addr_i;
logic instr_ready_o;
logic [soc_pkg::DATA_W-1:0] instr_rdata_o;
logic data_rd_i;
logic data_wr_i;
logic [soc_pkg::ADDR_W-1:0] data_addr_i;
logic [soc_pkg::DATA_W-1:0] data_wdata_i;
logic [soc_pkg::BE_W-1:0] data_be_i;
logic data_ready_o;
logic [soc_pkg::DATA_W-1:0] data_rdata_o;
logic [soc_pkg::LED_W-1:0] led_o;
logic [soc_pkg::ADDR_W-1:0] m_axi_awaddr_o, m_axi_araddr_o;
logic [soc_pkg::DATA_W-1:0] m_axi_wdata_o, m_axi_rdata_i;
logic [soc_pkg::BE_W-1:0] m_axi_wstrb_o;
logic m_axi_awvalid_o, m_axi_awready_i, m_axi_wvalid_o, m_axi_wready_i;
logic m_axi_bvalid_i, m_axi_bready_o, m_axi_arvalid_o, m_axi_arready_i;
logic m_axi_rvalid_i, m_axi_rready_o;
soc_pkg::axi_resp_t m_axi_bresp_i, m_axi_rresp_i;

int errors = 0;
logic [31:0] data_exp, instr_exp, ram_word;   // expected read words
logic [31:0] axi_addr_exp, axi_wdata_exp;
logic [3:0] axi_strb_exp;
logic [3:0] led_exp;
logic two_edge_check = 1'b0; // ram and led latency
logic led_check = 1'b0;
logic tmo_check = 1'b0;
logic data_won [2];          // tie winners
logic axi_idle;

soc_bus_top UUT (.*);

axi_lite_slave_model u_axi_slave (
	.clk_i           (clk_i),
	.rst_i           (rst_i),
	.s_axi_awaddr_i  (m_axi_awaddr_o),
	.s_axi_awvalid_i (m_axi_awvalid_o),
	.s_axi_awready_o (m_axi_awready_i),
	.s_axi_wdata_i   (m_axi_wdata_o),
	.s_axi_wstrb_i   (m_axi_wstrb_o),
	.s_axi_wvalid_i  (m_axi_wvalid_o),
	.s_axi_wready_o  (m_axi_wready_i),
	.s_axi_bresp_o   (m_axi_bresp_i),
	.s_axi_bvalid_o  (m_axi_bvalid_i),
	.s_axi_bready_i  (m_axi_bready_o),
	.s_axi_araddr_i  (m_axi_araddr_o),
	.s_axi_arvalid_i (m_axi_arvalid_o),
	.s_axi_arready_o (m_axi_arready_i),
	.s_axi_rdata_o   (m_axi_rdata_i),
	.s_axi_rresp_o   (m_axi_rresp_i),
	.s_axi_rvalid_o  (m_axi_rvalid_i),
	.s_axi_rready_i  (m_axi_rready_o)
);

initial begin
	clk_i = 1'b0;
	forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
end

assign axi_idle = !m_axi_awvalid_o && !m_axi_wvalid_o && !m_axi_arvalid_o
	&& !m_axi_bready_o && !m_axi_rready_o;

task automatic flag_error(input string msg);
	errors++;
	$display("[FAIL] %0t %s", $time, msg);
endtask

task automatic finish_run();
	$display("checks done, %0d error(s)", errors);
	if (errors == 0)
		$display("*** TEST PASSED ***");
	else
		$display("*** TEST FAILED ***");
	$finish;
endtask

// byte lanes with be set take the new word
function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
	input logic [3:0] be);
	logic [31:0] w;
	w = old_w;
	for (int b = 0; b < 4; b++) begin
		if (be[b])
			w[8*b +: 8] = new_w[8*b +: 8];
	end
	return w;
endfunction

// raise on an edge, hold until ready, drop on the ready edge
task automatic data_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
	input logic [3:0] be, output int waited);
	@(posedge clk_i);
	data_rd_i    <= !wr;
	data_wr_i    <= wr;
	data_addr_i  <= addr;
	data_wdata_i <= wdata;
	data_be_i    <= be;
	waited = 0;
	do begin
		@(posedge clk_i);
		waited++;
	end while (!data_ready_o);
	data_rd_i <= 1'b0;
	data_wr_i <= 1'b0;
endtask

task automatic instr_fetch(input logic [31:0] addr, output int waited);
	@(posedge clk_i);
	instr_rd_i   <= 1'b1;
	instr_addr_i <= addr;
	waited = 0;
	do begin
		@(posedge clk_i);
		waited++;
	end while (!instr_ready_o);
	instr_rd_i <= 1'b0;
endtask

// both ports raised in the same cycle, first ready wins
task automatic arbitrate_tie(input int idx);
	int d_wait;
	int i_wait;
	data_exp  = RAM_B_WORD;
	instr_exp = ram_word;
	fork
		data_access(1'b0, RAM_B, '0, 4'hF, d_wait);
		instr_fetch(RAM_A, i_wait);
	join
	data_won[idx] = (d_wait < i_wait);
endtask

// quiet outputs during reset and on the first edge out of it
assert property (@(posedge clk_i) !rst_i |=> !instr_ready_o && !data_ready_o
	&& led_o == '0 && axi_idle)
	else flag_error("outputs not idle during or right after reset");

assert property (@(posedge clk_i) disable iff (!rst_i)
	data_ready_o && data_rd_i |-> data_rdata_o == data_exp)
	else flag_error($sformatf("data read %h, expected %h",
		$sampled(data_rdata_o), $sampled(data_exp)));

assert property (@(posedge clk_i) disable iff (!rst_i)
	instr_ready_o |-> instr_rdata_o == instr_exp)
	else flag_error($sformatf("fetch read %h, expected %h",
		$sampled(instr_rdata_o), $sampled(instr_exp)));

// ready only to the requesting port, never both
assert property (@(posedge clk_i) disable iff (!rst_i)
	data_ready_o |-> (data_rd_i || data_wr_i) && !instr_ready_o)
	else flag_error("data ready without a data request");
assert property (@(posedge clk_i) disable iff (!rst_i) instr_ready_o |-> instr_rd_i)
	else flag_error("fetch ready without a fetch request");

// request seen, then ready two edges later
assert property (@(posedge clk_i) disable iff (!rst_i)
	two_edge_check && $rose(data_rd_i || data_wr_i)
	|-> !data_ready_o ##1 !data_ready_o ##1 data_ready_o)
	else flag_error("data access ready not two edges after the request");
assert property (@(posedge clk_i) disable iff (!rst_i)
	two_edge_check && $rose(instr_rd_i) |-> !instr_ready_o ##1 !instr_ready_o ##1 instr_ready_o)
	else flag_error("fetch ready not two edges after the request");

// led accesses stay off the axi port
assert property (@(posedge clk_i) disable iff (!rst_i)
	led_check |-> !m_axi_awvalid_o && !m_axi_wvalid_o && !m_axi_arvalid_o)
	else flag_error("axi valid raised during a led access");
assert property (@(posedge clk_i) disable iff (!rst_i)
	led_check && data_ready_o && data_wr_i |=> led_o == led_exp)
	else flag_error($sformatf("led %h, expected %h", $sampled(led_o), $sampled(led_exp)));

assert property (@(posedge clk_i) disable iff (!rst_i)
	m_axi_awvalid_o |-> m_axi_awaddr_o == axi_addr_exp)
	else flag_error($sformatf("awaddr %h, expected %h",
		$sampled(m_axi_awaddr_o), $sampled(axi_addr_exp)));
assert property (@(posedge clk_i) disable iff (!rst_i)
	m_axi_wvalid_o |-> m_axi_wstrb_o == axi_strb_exp && m_axi_wdata_o == axi_wdata_exp)
	else flag_error($sformatf("wdata %h wstrb %b, expected %h %b", $sampled(m_axi_wdata_o),
		$sampled(m_axi_wstrb_o), $sampled(axi_wdata_exp), $sampled(axi_strb_exp)));
assert property (@(posedge clk_i) disable iff (!rst_i)
	m_axi_arvalid_o |-> m_axi_araddr_o == axi_addr_exp)
	else flag_error($sformatf("araddr %h, expected %h",
		$sampled(m_axi_araddr_o), $sampled(axi_addr_exp)));

assert property (@(posedge clk_i) disable iff (!rst_i) tmo_check && data_ready_o |=> axi_idle)
	else flag_error("axi handshake signals still active after the timeout");

// hang guard, sized for the slowest possible access
initial begin
	#(CLK_PERIOD * (RESET_CYCLES + NUM_ACCESSES * (soc_pkg::AXI_TIMEOUT_CYCLES + 20)));
	errors++;
	$display("watchdog expired, the run hung waiting for a ready");
	finish_run();
end

initial begin
	int waited;
	rst_i        = 1'b0;
	instr_rd_i   = 1'b0;
	instr_addr_i = '0;
	data_rd_i    = 1'b0;
	data_wr_i    = 1'b0;
	data_addr_i  = '0;
	data_wdata_i = '0;
	data_be_i    = '0;
	repeat (RESET_CYCLES) @(posedge clk_i);
	rst_i <= 1'b1;

	// ram: full word, then bytes 0 and 2 only
	two_edge_check = 1'b1;
	ram_word = 32'h1122_3344;
	data_access(1'b1, RAM_A, ram_word, 4'hF, waited);
	ram_word = merge_bytes(ram_word, 32'hAABB_CCDD, 4'b0101);
	data_access(1'b1, RAM_A, 32'hAABB_CCDD, 4'b0101, waited);
	data_exp = ram_word;
	data_access(1'b0, RAM_A, '0, 4'h0, waited); // be unused on reads
	instr_exp = ram_word;
	instr_fetch(RAM_A, waited);

	// led register, be ignored
	led_check = 1'b1;
	led_exp   = 4'hA;
	data_access(1'b1, LED_A, 32'h1234_567A, 4'h0, waited);
	data_exp = {28'd0, led_exp};
	data_access(1'b0, LED_A, '0, 4'hF, waited);
	data_exp = ram_word; // ram word at same offset unchanged
	data_access(1'b0, RAM_A, '0, 4'hF, waited);
	led_check      = 1'b0;
	two_edge_check = 1'b0;

	// axi bridge, model stalls at random
	axi_addr_exp  = AXI_A;
	axi_wdata_exp = 32'hCAFE_F00D;
	axi_strb_exp  = 4'hF;
	data_access(1'b1, AXI_A, axi_wdata_exp, axi_strb_exp, waited);
	axi_addr_exp  = AXI_A + 4;
	axi_wdata_exp = 32'h1234_5678;
	axi_strb_exp  = 4'b0011;
	data_access(1'b1, AXI_A + 4, axi_wdata_exp, axi_strb_exp, waited);
	axi_addr_exp = AXI_A;
	data_exp     = 32'hCAFE_F00D;
	data_access(1'b0, AXI_A, '0, 4'hF, waited);
	axi_addr_exp = AXI_A + 4;
	data_exp     = merge_bytes('0, 32'h1234_5678, 4'b0011);
	data_access(1'b0, AXI_A + 4, '0, 4'hF, waited);

	// two ties in a row, winners must alternate
	data_access(1'b1, RAM_B, RAM_B_WORD, 4'hF, waited);
	arbitrate_tie(0);
	arbitrate_tie(1);
	assert (data_won[0] != data_won[1])
		else flag_error("tie winners did not alternate");

	// silent slave, bridge gives up
	tmo_check    = 1'b1;
	axi_addr_exp = SILENT_A;
	data_exp     = soc_pkg::TIMEOUT_RDATA;
	data_access(1'b0, SILENT_A, '0, 4'hF, waited);
	assert (waited >= soc_pkg::AXI_TIMEOUT_CYCLES)
		else flag_error($sformatf("timeout after only %0d cycles", waited));
	two_edge_check = 1'b1; // ram must be back to normal
	data_exp       = ram_word;
	data_access(1'b0, RAM_A, '0, 4'hF, waited);
	repeat (2) @(posedge clk_i); // let the last checks fire
	finish_run();
end

endmodule

// File: vlog.f
design/soc_pkg.sv
design/mem_req_if.sv
design/mem_arbiter.sv
design/bus_decoder.sv
design/ram_block.sv
design/axi_timeout_timer.sv
design/axi_lite_master.sv
design/soc_bus_top.sv
tb/axi_lite_slave_model.sv
tb/tb_soc_bus.sv
